// ==== include/pbus_defs.svh ====
`ifndef PBUS_DEFS_SVH
`define PBUS_DEFS_SVH

// Shared bus width, upper byte starts here
`define PBUS_WIDTH 24
`define PBUS_UPPER_LSB 16

// Slot ranges within the 32-phase line schedule, inclusive
`define FIXT_FIRST 0
`define FIXT_LAST 2
`define IDLE_FIRST 3
`define IDLE_LAST 12
`define FP_FIRST 13
`define FP_LAST 14
`define SPRT_FIRST 15
`define SPRT_LAST 17
`define L0_FIRST 18
`define L0_LAST 27
`define L0CAP 28
`define SP_FIRST 29
`define SP_LAST 31

// Strobe phases, decoded one cycle ahead of the outputs
`define PCK2_FIRST 0
`define PCK2_LAST 1
`define PCK1_FIRST 15
`define PCK1_LAST 16
`define LOAD_A_FIRST 6
`define LOAD_A_LAST 7
`define LOAD_B_FIRST 14
`define LOAD_B_LAST 15

// Counter values seen while a slot word is on the bus
`define FP_CAP 15
`define SP_CAP 0
`define L0_READ 29

`endif

// ==== hw/pbusPkg.sv ====
`default_nettype none

package pbusPkg;

	// Line phase, 32 slots per schedule
	typedef logic [4:0] phase_t;

	// Fix ROM address, bit 3 (S2H1) not carried
	// {addr[16:4], addr[2:0]}
	typedef logic [15:0] fixRomAddr_t;

	// Sprite ROM address, bit 4 (CA4) not carried
	// {addr[24:5], addr[3:0]}
	typedef logic [23:0] sprRomAddr_t;

	// One bus word, read as fix tile or as sprite tile
	typedef union packed
	{
		// FIXT slot layout
		struct packed
		{
			// Upper byte, zero here or palette in FP
			logic [7:0] upper;
			// Tile bit 4
			logic tileBit4;
			// Address bits 2 to 0
			logic [2:0] line;
			// Address bits 16 to 5
			logic [11:0] tile;
		} fixView;
		// SPRT slot layout
		struct packed
		{
			// Address bits 24 to 21
			logic [3:0] hi;
			// Address bits 3 to 0
			logic [3:0] line;
			// Address bits 20 to 5, X position sits in top byte during SP
			logic [15:0] mid;
		} sprView;
	} pbusWord_u;

endpackage

`default_nettype wire

// ==== hw/pCycleTimer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pbus_defs.svh"

module pCycleTimer
	import pbusPkg::*;
(
	input logic CLK_24M,
	input logic nCLK_24M,
	input logic hsync,
	output phase_t phase,
	output logic pck1,
	output logic pck2,
	output logic load,
	output logic nVcs
);

	// Inclusive range test against slot macros
	function automatic logic inSpan(input phase_t p, input int unsigned first,
		input int unsigned last);
		return (p >= first) && (p <= last);
	endfunction

	// Line phase counter
	// Held at zero through HSYNC, free-running after
	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
		begin
			phase <= '0;
		end
		else if (hsync)
		begin
			phase <= '0;
		end
		else
		begin
			// 5-bit wrap 31 to 0
			phase <= phase + 1'b1;
		end
	end

	// Strobes decoded from current phase, so they line up with bus word
	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
		begin
			pck1 <= 1'b0;
			pck2 <= 1'b0;
			load <= 1'b0;
			nVcs <= 1'b1;
		end
		else if (hsync)
		begin
			// Idle levels during sync
			pck1 <= 1'b0;
			pck2 <= 1'b0;
			load <= 1'b0;
			nVcs <= 1'b1;
		end
		else
		begin
			// Fix address latch
			pck2 <= inSpan(phase, `PCK2_FIRST, `PCK2_LAST);
			// Sprite address latch
			pck1 <= inSpan(phase, `PCK1_FIRST, `PCK1_LAST);
			// Two pulses per line
			load <= inSpan(phase, `LOAD_A_FIRST, `LOAD_A_LAST) ||
				inSpan(phase, `LOAD_B_FIRST, `LOAD_B_LAST);
			// L0 window plus the read-back cycle
			nVcs <= !inSpan(phase, `L0_FIRST, `L0CAP);
		end
	end

endmodule

`default_nettype wire

// ==== hw/pBusMux.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pbus_defs.svh"

module pBusMux
	import pbusPkg::*;
(
	input logic CLK_24M,
	input logic nCLK_24M,
	input logic hsync,
	input phase_t phase,
	input logic [16:0] fixAddr,
	input logic [3:0] fixPal,
	input logic [24:0] sprAddr,
	input logic [7:0] sprPal,
	input logic [7:0] sprXpos,
	input logic [15:0] l0Addr,
	output logic [7:0] l0Data,
	inout wire [`PBUS_WIDTH-1:0] pbus
);

	// Word for the current phase, before the output register
	logic [`PBUS_WIDTH-1:0] nextWord;
	logic nextOe;

	// Registered bus word and upper byte enable
	logic [`PBUS_WIDTH-1:0] busWord;
	logic upperOe;

	// Slot select
	always_comb
	begin
		nextWord = '0;
		nextOe = 1'b1;
		case (phase) inside
			[`FIXT_FIRST:`FIXT_LAST]:
			begin
				// Fix tile, S2H1 bit dropped
				nextWord = {8'h00, fixAddr[4], fixAddr[2:0], fixAddr[16:5]};
			end
			[`IDLE_FIRST:`IDLE_LAST]:
			begin
				// Idle pattern FF0000
				nextWord = {8'hff, 16'h0000};
			end
			[`FP_FIRST:`FP_LAST]:
			begin
				// Fix palette in low nibble of upper byte
				nextWord = {4'h0, fixPal, 16'h0000};
			end
			[`SPRT_FIRST:`SPRT_LAST]:
			begin
				// Sprite tile, CA4 bit dropped
				nextWord = {sprAddr[24:21], sprAddr[3:0], sprAddr[20:5]};
			end
			[`L0_FIRST:`L0CAP]:
			begin
				// Upper byte handed over to the L0 ROM
				nextWord = {8'h00, l0Addr};
				nextOe = 1'b0;
			end
			[`SP_FIRST:`SP_LAST]:
			begin
				// X position and palette
				nextWord = {sprPal, sprXpos, 8'h00};
			end
			default:
			begin
				nextWord = '0;
				nextOe = 1'b1;
			end
		endcase
	end

	// Output register, zero word during sync
	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
		begin
			busWord <= '0;
			upperOe <= 1'b1;
		end
		else if (hsync)
		begin
			busWord <= '0;
			upperOe <= 1'b1;
		end
		else
		begin
			busWord <= nextWord;
			upperOe <= nextOe;
		end
	end

	// Lower 16 bits always driven
	assign pbus[`PBUS_UPPER_LSB-1:0] = busWord[`PBUS_UPPER_LSB-1:0];
	assign pbus[`PBUS_WIDTH-1:`PBUS_UPPER_LSB] = upperOe ?
		busWord[`PBUS_WIDTH-1:`PBUS_UPPER_LSB] : 'z;

	// L0 read-back, last cycle nVCS still low
	always_ff @(posedge CLK_24M)
	begin
		if (phase == `L0_READ)
		begin
			l0Data <= pbus[`PBUS_WIDTH-1:`PBUS_UPPER_LSB];
		end
	end

endmodule

`default_nettype wire

// ==== hw/pBusLatch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pbus_defs.svh"

module pBusLatch
	import pbusPkg::*;
(
	input logic CLK_24M,
	input logic nCLK_24M,
	input logic [`PBUS_WIDTH-1:0] pbus,
	input logic pck1,
	input logic pck2,
	input phase_t phase,
	output fixRomAddr_t fixRom,
	output logic [3:0] fixPalOut,
	output sprRomAddr_t sprRom,
	output logic [7:0] sprPalOut,
	output logic [7:0] sprXOut
);

	// Bus seen through both views
	pbusWord_u busView;

	// Strobe history, second cycle detect
	logic pck1Seen;
	logic pck2Seen;
	// Sprite tile taken this line, X and palette still to come
	logic sprArmed;

	logic fixTake;
	logic sprTake;
	logic spTake;

	assign busView = pbus;

	// Edge that ends each strobe's second cycle
	assign fixTake = pck2 && pck2Seen;
	assign sprTake = pck1 && pck1Seen;
	// SP word on the bus right after the wrap
	assign spTake = (phase == `SP_CAP) && sprArmed;

	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
		begin
			pck1Seen <= 1'b0;
			pck2Seen <= 1'b0;
			sprArmed <= 1'b0;
		end
		else
		begin
			pck1Seen <= pck1;
			pck2Seen <= pck2;
			if (sprTake)
				sprArmed <= 1'b1;
			else if (spTake)
				sprArmed <= 1'b0;
		end
	end

	// Address and attribute latches
	always_ff @(posedge CLK_24M)
	begin
		// Fix ROM address, S2H1 gap closed up
		if (fixTake)
			fixRom <= {busView.fixView.tile, busView.fixView.tileBit4, busView.fixView.line};
		// Palette nibble from FP slot
		if (phase == `FP_CAP)
			fixPalOut <= busView.fixView.upper[3:0];
		// Sprite ROM address, CA4 gap closed up
		if (sprTake)
			sprRom <= {busView.sprView.hi, busView.sprView.mid, busView.sprView.line};
		// palette on upper byte, X in top of the middle field
		if (spTake)
		begin
			sprPalOut <= busView.fixView.upper;
			sprXOut <= busView.sprView.mid[15:8];
		end
	end

endmodule

`default_nettype wire

// ==== hw/l0RomPort.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pbus_defs.svh"

module l0RomPort
(
	input logic CLK_24M,
	input logic nCLK_24M,
	input logic nVcs,
	input logic [7:0] romData,
	output logic [15:0] romAddr,
	inout wire [`PBUS_WIDTH-1:0] pbus
);

	// nVCS one cycle back, for the falling edge
	logic nVcsDly;
	logic addrTake;

	always_ff @(posedge CLK_24M or posedge nCLK_24M)
	begin
		if (nCLK_24M)
		begin
			nVcsDly <= 1'b1;
		end
		else
		begin
			nVcsDly <= nVcs;
		end
	end

	// First cycle of the select window
	assign addrTake = !nVcs && nVcsDly;

	// Address held for the whole window
	always_ff @(posedge CLK_24M)
	begin
		if (addrTake)
		begin
			romAddr <= pbus[`PBUS_UPPER_LSB-1:0];
		end
	end

	// ROM data back onto the upper byte while selected
	assign pbus[`PBUS_WIDTH-1:`PBUS_UPPER_LSB] = nVcs ? 'z : romData;

endmodule

`default_nettype wire

// ==== hw/neoPbus.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "pbus_defs.svh"

module neoPbus
	import pbusPkg::*;
(
	input logic CLK_24M,
	input logic nCLK_24M,
	input logic HSYNC,
	input logic [16:0] fixAddr,
	input logic [3:0] fixPal,
	input logic [24:0] sprAddr,
	input logic [7:0] sprPal,
	input logic [7:0] sprXpos,
	input logic [15:0] l0Addr,
	input logic [7:0] l0RomData,
	output logic PCK1,
	output logic PCK2,
	output logic LOAD,
	output logic nVCS,
	output logic [7:0] l0Data,
	output logic [15:0] l0RomAddr,
	output fixRomAddr_t fixRom,
	output logic [3:0] fixPalOut,
	output sprRomAddr_t sprRom,
	output logic [7:0] sprPalOut,
	output logic [7:0] sprXOut
);

	// Shared bus, upper byte has two drivers
	wire [`PBUS_WIDTH-1:0] pbus;
	// Line phase
	phase_t linePhase;

	// Schedule and strobes
	pCycleTimer i_cycleTimer (
		.CLK_24M(CLK_24M),
		.nCLK_24M(nCLK_24M),
		.hsync(HSYNC),
		.phase(linePhase),
		.pck1(PCK1),
		.pck2(PCK2),
		.load(LOAD),
		.nVcs(nVCS)
	);

	// Sequencer side
	pBusMux i_busMux (
		.CLK_24M(CLK_24M),
		.nCLK_24M(nCLK_24M),
		.hsync(HSYNC),
		.phase(linePhase),
		.fixAddr(fixAddr),
		.fixPal(fixPal),
		.sprAddr(sprAddr),
		.sprPal(sprPal),
		.sprXpos(sprXpos),
		.l0Addr(l0Addr),
		.l0Data(l0Data),
		.pbus(pbus)
	);

	// ROM side
	pBusLatch i_busLatch (
		.CLK_24M(CLK_24M),
		.nCLK_24M(nCLK_24M),
		.pbus(pbus),
		.pck1(PCK1),
		.pck2(PCK2),
		.phase(linePhase),
		.fixRom(fixRom),
		.fixPalOut(fixPalOut),
		.sprRom(sprRom),
		.sprPalOut(sprPalOut),
		.sprXOut(sprXOut)
	);

	// L0 ROM answers on the upper byte
	l0RomPort i_l0RomPort (
		.CLK_24M(CLK_24M),
		.nCLK_24M(nCLK_24M),
		.nVcs(nVCS),
		.romData(l0RomData),
		.romAddr(l0RomAddr),
		.pbus(pbus)
	);

endmodule

`default_nettype wire

// ==== sim/tbNeoPbus.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbNeoPbus
	import pbusPkg::*;
();

	localparam int rowCount = 8;
	// Cycles per schedule and settle time after HSYNC falls
	localparam int lineCycles = 32;
	localparam int settleCycles = 40;
	localparam int lineTimeout = 80;

	logic CLK_24M;
	logic nCLK_24M;
	logic HSYNC;
	logic [16:0] fixAddr;
	logic [3:0] fixPal;
	logic [24:0] sprAddr;
	logic [7:0] sprPal;
	logic [7:0] sprXpos;
	logic [15:0] l0Addr;
	logic [7:0] l0RomData;
	logic PCK1;
	logic PCK2;
	logic LOAD;
	logic nVCS;
	logic [7:0] l0Data;
	logic [15:0] l0RomAddr;
	fixRomAddr_t fixRom;
	logic [3:0] fixPalOut;
	sprRomAddr_t sprRom;
	logic [7:0] sprPalOut;
	logic [7:0] sprXOut;

	// Stimulus table, one row per line
	logic [16:0] fixAddrTab [0:rowCount-1];
	logic [3:0] fixPalTab [0:rowCount-1];
	logic [24:0] sprAddrTab [0:rowCount-1];
	logic [7:0] sprPalTab [0:rowCount-1];
	logic [7:0] sprXposTab [0:rowCount-1];
	logic [15:0] l0AddrTab [0:rowCount-1];

	logic [31:0] lfsrState;

	neoPbus i_neoPbus (
		.CLK_24M(CLK_24M),
		.nCLK_24M(nCLK_24M),
		.HSYNC(HSYNC),
		.fixAddr(fixAddr),
		.fixPal(fixPal),
		.sprAddr(sprAddr),
		.sprPal(sprPal),
		.sprXpos(sprXpos),
		.l0Addr(l0Addr),
		.l0RomData(l0RomData),
		.PCK1(PCK1),
		.PCK2(PCK2),
		.LOAD(LOAD),
		.nVCS(nVCS),
		.l0Data(l0Data),
		.l0RomAddr(l0RomAddr),
		.fixRom(fixRom),
		.fixPalOut(fixPalOut),
		.sprRom(sprRom),
		.sprPalOut(sprPalOut),
		.sprXOut(sprXOut)
	);

	// L0 ROM model, low byte XOR high byte
	assign l0RomData = l0RomAddr[7:0] ^ l0RomAddr[15:8];

	// 125 MHz-ish bench clock, 8 ns period
	always #4 CLK_24M = ~CLK_24M;

	// Right-shift Galois form
	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] drawBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsrState[0]};
			lfsrState = galoisStep(lfsrState);
		end
		return v;
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkFixRom(input string name, input fixRomAddr_t got,
		input fixRomAddr_t exp);
		if (got !== exp)
			failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic checkSprRom(input string name, input sprRomAddr_t got,
		input sprRomAddr_t exp);
		if (got !== exp)
			failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic checkWord(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp)
			failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic checkByte(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp)
			failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp)
			failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic checkCount(input string name, input int got, input int exp);
		if (got != exp)
			failRun($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic stepDrive();
		@(posedge CLK_24M);
		#1;
	endtask

	task automatic fillTable();
		// All ones
		fixAddrTab[0] = '1;
		fixPalTab[0] = '1;
		sprAddrTab[0] = '1;
		sprPalTab[0] = '1;
		sprXposTab[0] = '1;
		l0AddrTab[0] = '1;
		// Only the dropped bits set, ROM addresses should read zero
		fixAddrTab[1] = 17'h00008;
		fixPalTab[1] = 4'h1;
		sprAddrTab[1] = 25'h0000010;
		sprPalTab[1] = 8'h80;
		sprXposTab[1] = 8'h01;
		l0AddrTab[1] = 16'h8000;
		// Top bits alone
		fixAddrTab[2] = 17'h10000;
		fixPalTab[2] = 4'h8;
		sprAddrTab[2] = 25'h1000000;
		sprPalTab[2] = 8'h01;
		sprXposTab[2] = 8'h80;
		l0AddrTab[2] = 16'h0001;
		for (int r = 3; r < rowCount; r++)
		begin
			fixAddrTab[r] = 17'(drawBits(17));
			fixPalTab[r] = 4'(drawBits(4));
			sprAddrTab[r] = 25'(drawBits(25));
			sprPalTab[r] = 8'(drawBits(8));
			sprXposTab[r] = 8'(drawBits(8));
			l0AddrTab[r] = 16'(drawBits(16));
		end
	endtask

	// One line: pulse HSYNC, watch strobes, then check latched outputs
	task automatic runLine(input int r);
		int cycle;
		int pck2High;
		int pck1High;
		int loadHigh;
		int nVcsLow;
		int nVcsRuns;
		int pck2Rises;
		int pck2Rise0;
		int pck2Rise1;
		int pck1Rise;
		logic prevPck2;
		logic prevPck1;
		logic prevNVcs;
		stepDrive();
		HSYNC = 1'b1;
		fixAddr = fixAddrTab[r];
		fixPal = fixPalTab[r];
		sprAddr = sprAddrTab[r];
		sprPal = sprPalTab[r];
		sprXpos = sprXposTab[r];
		l0Addr = l0AddrTab[r];
		repeat (3)
			stepDrive();
		HSYNC = 1'b0;
		cycle = 0;
		pck2High = 0;
		pck1High = 0;
		loadHigh = 0;
		nVcsLow = 0;
		nVcsRuns = 0;
		pck2Rises = 0;
		pck2Rise0 = -1;
		pck2Rise1 = -1;
		pck1Rise = -1;
		prevPck2 = 1'b0;
		prevPck1 = 1'b0;
		prevNVcs = 1'b1;
		// Cycle 0 is the half cycle before the first edge with HSYNC low
		while (!(pck2Rises >= 2 && cycle > settleCycles))
		begin
			if (cycle > lineTimeout)
				failRun($sformatf("Timed out waiting for the second PCK2 pulse, row %0d", r));
			@(negedge CLK_24M);
			// Strobe widths over exactly one schedule
			if (cycle >= 1 && cycle <= lineCycles)
			begin
				pck2High += PCK2;
				pck1High += PCK1;
				loadHigh += LOAD;
				nVcsLow += !nVCS;
				if (!nVCS && prevNVcs)
					nVcsRuns++;
			end
			if (PCK2 && !prevPck2)
			begin
				if (pck2Rises == 0)
					pck2Rise0 = cycle;
				else if (pck2Rises == 1)
					pck2Rise1 = cycle;
				pck2Rises++;
			end
			if (PCK1 && !prevPck1 && pck1Rise < 0)
				pck1Rise = cycle;
			prevPck2 = PCK2;
			prevPck1 = PCK1;
			prevNVcs = nVCS;
			cycle++;
		end
		checkCount($sformatf("PCK2 high cycles row %0d", r), pck2High, 2);
		checkCount($sformatf("PCK1 high cycles row %0d", r), pck1High, 2);
		checkCount($sformatf("LOAD high cycles row %0d", r), loadHigh, 4);
		checkCount($sformatf("nVCS low cycles row %0d", r), nVcsLow, 11);
		checkCount($sformatf("nVCS low runs row %0d", r), nVcsRuns, 1);
		checkCount($sformatf("PCK2 rise interval row %0d", r), pck2Rise1 - pck2Rise0,
			lineCycles);
		if (pck1Rise < 0 || pck1Rise <= pck2Rise0)
			failRun($sformatf("PCK1 did not rise after PCK2 in the line of row %0d", r));
		// Expected words straight from the input fields
		checkFixRom($sformatf("fixRom row %0d", r), fixRom,
			{fixAddrTab[r][16:4], fixAddrTab[r][2:0]});
		checkByte($sformatf("fixPalOut row %0d", r), {4'h0, fixPalOut}, {4'h0, fixPalTab[r]});
		checkSprRom($sformatf("sprRom row %0d", r), sprRom,
			{sprAddrTab[r][24:5], sprAddrTab[r][3:0]});
		checkByte($sformatf("sprPalOut row %0d", r), sprPalOut, sprPalTab[r]);
		checkByte($sformatf("sprXOut row %0d", r), sprXOut, sprXposTab[r]);
		checkWord($sformatf("l0RomAddr row %0d", r), l0RomAddr, l0AddrTab[r]);
		checkByte($sformatf("l0Data row %0d", r), l0Data,
			l0AddrTab[r][7:0] ^ l0AddrTab[r][15:8]);
	endtask

	initial
	begin
		CLK_24M = 1'b0;
		nCLK_24M = 1'b1;
		HSYNC = 1'b0;
		fixAddr = '0;
		fixPal = '0;
		sprAddr = '0;
		sprPal = '0;
		sprXpos = '0;
		l0Addr = '0;
		lfsrState = 32'h1b50_0ea7;
		fillTable();
		repeat (10)
			@(posedge CLK_24M);
		#1;
		nCLK_24M = 1'b0;
		// Idle levels before the next edge can move the schedule
		@(negedge CLK_24M);
		checkBit("PCK1 after reset", PCK1, 1'b0);
		checkBit("PCK2 after reset", PCK2, 1'b0);
		checkBit("LOAD after reset", LOAD, 1'b0);
		checkBit("nVCS after reset", nVCS, 1'b1);
		for (int r = 0; r < rowCount; r++)
			runLine(r);
		$display("PASS: all tests");
		$finish;
	end

	// Whole-run limit
	initial
	begin
		#20000;
		$display("Simulation ran past its time limit without finishing");
		$display("FAIL: see errors above");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+include
hw/pbusPkg.sv
hw/pCycleTimer.sv
hw/pBusMux.sv
hw/pBusLatch.sv
hw/l0RomPort.sv
hw/neoPbus.sv
sim/tbNeoPbus.sv
